//--- Bender.yml
package:
  name: read_cache

sources:
  - read_cache_pkg.sv
  - ahb_read_port.sv
  - cache_line_store.sv
  - cache_refill_ctrl.sv
  - read_cache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_read_cache.sv

//--- ahb_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_read_port
    import read_cache_pkg::*;
(
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] haddr,
    input  htrans_e           htrans,
    input  logic              hwrite,
    input  hburst_e           hburst,
    input  logic [2:0]        hsize,
    output logic              hready,
    output logic [DATA_W-1:0] hrdata,
    output hresp_e            hresp,
    output logic              lookup_valid,
    output lookup_t           lookup,
    input  logic              lookup_done,
    input  logic [DATA_W-1:0] rdata
);

    logic addr_phase;
    logic supported;
    logic err_first;
    logic err_second;

    // a transfer is accepted only while the previous data phase completes
    assign addr_phase = hready && (htrans == NONSEQ || htrans == SEQ);

    assign supported = !hwrite && (hburst == SINGLE) && (hsize == HSIZE_WORD);

    // the stall lasts from the data phase start until the controller answers
    assign hready = !err_first && !(lookup_valid && !lookup_done);
    assign hresp  = (err_first || err_second) ? ERROR : OKAY;
    assign hrdata = rdata;

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            lookup_valid <= 1'b0;
            err_first    <= 1'b0;
            err_second   <= 1'b0;
        end else begin
            err_first  <= addr_phase && !supported;  // first ERROR cycle holds hready low
            err_second <= err_first;
            if (hready) begin
                lookup_valid <= addr_phase && supported;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (addr_phase) begin
            lookup <= split_addr(haddr);
        end
    end

endmodule

`default_nettype wire

//--- cache_line_store.sv
`timescale 1ns/100ps
`default_nettype none

module cache_line_store
    import read_cache_pkg::*;
(
    input  logic               cpu_intf,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0]   lookup_tag,
    output logic               hit,
    output logic [DATA_W-1:0]  hit_data,
    input  logic               fill_en,
    input  fill_t              fill
);

    logic [LINE_COUNT-1:0] line_valid;
    logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];
    logic [DATA_W-1:0]     data_mem [LINE_COUNT];

    logic [TAG_W-1:0] stored_tag;

    assign stored_tag = tag_mem[lookup_index];

    // direct mapped, so one compare decides the hit
    assign hit      = line_valid[lookup_index] && (stored_tag == lookup_tag);
    assign hit_data = data_mem[lookup_index];

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill.index] <= 1'b1;
        end
    end

    // a fill replaces whatever tag the line held before
    always_ff @(posedge cpu_intf) begin
        if (fill_en) begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.data;
        end
    end

endmodule

`default_nettype wire

//--- cache_refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_refill_ctrl
    import read_cache_pkg::*;
(
    input  logic               cpu_intf,
    input  logic               rst_n,
    input  logic               lookup_valid,
    input  lookup_t            lookup,
    output logic               lookup_done,
    output logic [DATA_W-1:0]  rdata,
    output logic [INDEX_W-1:0] lookup_index,
    input  logic               hit,
    input  logic [DATA_W-1:0]  hit_data,
    output logic               fill_en,
    output fill_t              fill,
    output logic               mem_req,
    output mem_req_t           mem_addr,
    input  logic               mem_ack,
    input  logic [DATA_W-1:0]  mem_rdata
);

    refill_state_e state;

    logic miss;
    logic start_req;
    logic ack_taken;

    assign lookup_index = lookup.index;
    assign miss         = lookup_valid && !hit;

    // a request only starts once the previous ack has been released
    assign start_req = !mem_ack &&
                       ((state == ST_LOOKUP && miss) || state == ST_MEM_WAIT_LOW);
    assign ack_taken = (state == ST_MEM_REQ) && mem_ack;

    // RESPOND spends its first cycle on the fill and answers in the second
    assign lookup_done = (state == ST_LOOKUP && lookup_valid && hit) ||
                         (state == ST_RESPOND && !fill_en);

    assign rdata = (state == ST_RESPOND) ? fill.data : hit_data;

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            fill_en <= 1'b0;
        end else begin
            fill_en <= ack_taken;
            if (start_req) begin
                mem_req <= 1'b1;
            end else if (ack_taken) begin
                mem_req <= 1'b0;  // phase 3 of the handshake
            end
            case (state)
                ST_IDLE: begin
                    if (!mem_ack) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (miss) begin
                        state <= mem_ack ? ST_MEM_WAIT_LOW : ST_MEM_REQ;
                    end
                end
                ST_MEM_WAIT_LOW: begin
                    if (!mem_ack) begin
                        state <= ST_MEM_REQ;
                    end
                end
                ST_MEM_REQ: begin
                    if (mem_ack) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (lookup_done) begin
                        state <= ST_LOOKUP;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (start_req) begin
            mem_addr <= mem_req_t'(lookup);  // lookup_t already is address bits 31 down to 2
        end
        if (ack_taken) begin
            fill.tag   <= lookup.tag;
            fill.index <= lookup.index;
            fill.data  <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
read_cache_pkg.sv
ahb_read_port.sv
cache_line_store.sv
cache_refill_ctrl.sv
read_cache_top.sv
tb_mem_model.sv
tb_read_cache.sv

//--- read_cache_pkg.sv
`default_nettype none

package read_cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_COUNT = 16;
    localparam int INDEX_W    = $clog2(LINE_COUNT);  // 4 bits for 16 lines
    localparam int INDEX_LSB  = 2;                   // byte offset inside the word
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;
    localparam int TAG_W      = ADDR_W - TAG_LSB;    // 26 bits

    localparam logic [2:0] HSIZE_WORD = 3'b010;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // prefixed so they do not collide with the htrans names
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_REQ,
        ST_MEM_WAIT_LOW,
        ST_RESPOND
    } refill_state_e;

    // tag sits above index, so the struct reads as address bits 31 down to 2
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } lookup_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [DATA_W-1:0]  data;
    } fill_t;

    typedef struct packed {
        logic [ADDR_W-INDEX_LSB-1:0] word_addr;
    } mem_req_t;

    function automatic lookup_t split_addr(input logic [ADDR_W-1:0] addr);
        lookup_t l;
        l.tag   = addr[ADDR_W-1:TAG_LSB];
        l.index = addr[TAG_LSB-1:INDEX_LSB];
        return l;
    endfunction

endpackage

`default_nettype wire

//--- read_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module read_cache_top
    import read_cache_pkg::*;
(
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] haddr,
    input  htrans_e           htrans,
    input  logic              hwrite,
    input  hburst_e           hburst,
    input  logic [2:0]        hsize,
    output logic              hready,
    output logic [DATA_W-1:0] hrdata,
    output hresp_e            hresp,
    output logic              mem_req,
    output mem_req_t          mem_addr,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_rdata
);

    logic               lookup_valid;
    lookup_t            lookup;
    logic               lookup_done;
    logic [DATA_W-1:0]  rdata;
    logic [INDEX_W-1:0] lookup_index;
    logic               hit;
    logic [DATA_W-1:0]  hit_data;
    logic               fill_en;
    fill_t              fill;

    ahb_read_port u_ahb_read_port (
        .cpu_intf     (cpu_intf),
        .rst_n        (rst_n),
        .haddr        (haddr),
        .htrans       (htrans),
        .hwrite       (hwrite),
        .hburst       (hburst),
        .hsize        (hsize),
        .hready       (hready),
        .hrdata       (hrdata),
        .hresp        (hresp),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .lookup_done  (lookup_done),
        .rdata        (rdata)
    );

    cache_refill_ctrl u_cache_refill_ctrl (
        .cpu_intf     (cpu_intf),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .lookup_done  (lookup_done),
        .rdata        (rdata),
        .lookup_index (lookup_index),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_en      (fill_en),
        .fill         (fill),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    cache_line_store u_cache_line_store (
        .cpu_intf     (cpu_intf),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup.tag),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_en      (fill_en),
        .fill         (fill)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model
    import read_cache_pkg::*;
#(
    parameter logic [DATA_W-1:0] DATA_KEY = '0
) (
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic              mem_req,
    input  mem_req_t          mem_addr,
    input  logic [7:0]        ack_delay,
    output logic              mem_ack,
    output logic [DATA_W-1:0] mem_rdata,
    output logic [31:0]       req_count
);

    int wait_cnt;

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        req_count = '0;
        wait_cnt  = 0;
        forever begin
            @(negedge cpu_intf);  // memory drives its outputs on the falling edge
            if (!rst_n) begin
                mem_ack   = 1'b0;
                req_count = '0;
                wait_cnt  = 0;
            end else if (mem_req && !mem_ack) begin
                if (wait_cnt >= ack_delay) begin
                    mem_ack   = 1'b1;  // phase 2, data valid with the ack
                    mem_rdata = {2'b00, mem_addr.word_addr} ^ DATA_KEY;
                    req_count = req_count + 1;
                    wait_cnt  = 0;
                end else begin
                    wait_cnt++;
                end
            end else if (!mem_req && mem_ack) begin
                mem_ack   = 1'b0;  // phase 4
                mem_rdata = 'x;    // a late capture shows up as unknown data
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_read_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_read_cache
    import read_cache_pkg::*;
();

    localparam logic [DATA_W-1:0] DATA_KEY = 32'hC0DE_0000;
    localparam int DEFAULT_DELAY = 1;
    localparam int SLOW_DELAY    = 7;
    localparam int MIX_DELAY     = 2;
    localparam int MIX_READS     = 60;
    localparam int TRANSFER_COUNT  = 10 + MIX_READS;  // directed transfers plus the random mix
    localparam int WORST_TRANSFER  = SLOW_DELAY + 6;  // ack wait plus request, fill and respond
    localparam int WATCHDOG_CYCLES = TRANSFER_COUNT * WORST_TRANSFER + 200;

    logic              cpu_intf;
    logic              rst_n;
    logic [ADDR_W-1:0] haddr;
    htrans_e           htrans;
    logic              hwrite;
    hburst_e           hburst;
    logic [2:0]        hsize;
    logic              hready;
    logic [DATA_W-1:0] hrdata;
    hresp_e            hresp;
    logic              mem_req;
    mem_req_t          mem_addr;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_rdata;
    logic [7:0]        ack_delay;
    logic [31:0]       req_count;

    logic              sb_valid [LINE_COUNT];  // which tag each index holds
    logic [TAG_W-1:0]  sb_tag   [LINE_COUNT];
    int                predicted_misses;
    integer            seed;

    read_cache_top u_read_cache_top (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hburst    (hburst),
        .hsize     (hsize),
        .hready    (hready),
        .hrdata    (hrdata),
        .hresp     (hresp),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_mem_model #(.DATA_KEY(DATA_KEY)) u_mem_model (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .ack_delay (ack_delay),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .req_count (req_count)
    );

    initial begin
        cpu_intf = 1'b0;
        forever #2 cpu_intf = ~cpu_intf;
    end

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return {2'b00, addr[ADDR_W-1:2]} ^ DATA_KEY;
    endfunction

    function automatic logic predict_hit(input logic [ADDR_W-1:0] addr);
        return sb_valid[addr[5:2]] && (sb_tag[addr[5:2]] == addr[31:6]);
    endfunction

    task automatic record_fill(input logic [ADDR_W-1:0] addr);
        sb_valid[addr[5:2]] = 1'b1;
        sb_tag[addr[5:2]]   = addr[31:6];  // a fill evicts whatever tag was there
        predicted_misses++;
    endtask

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic drive_read(input logic [ADDR_W-1:0] addr);
        haddr  = addr;
        htrans = NONSEQ;
        hwrite = 1'b0;
        hburst = SINGLE;
        hsize  = HSIZE_WORD;
    endtask

    // counts falling edges with hready low; returns on the edge before the data phase ends
    task automatic wait_data_phase(output int stall);
        stall = 0;
        while (!hready) begin
            stall++;
            @(negedge cpu_intf);
        end
    endtask

    task automatic ahb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output hresp_e resp, output int stall);
        @(negedge cpu_intf);
        drive_read(addr);
        @(posedge cpu_intf);
        @(negedge cpu_intf);
        htrans = IDLE;
        wait_data_phase(stall);
        data = hrdata;
        resp = hresp;
        @(posedge cpu_intf);
    endtask

    task automatic read_and_check(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] data;
        hresp_e            resp;
        int                stall;
        logic              hit_expected;
        logic [31:0]       count_before;
        hit_expected = predict_hit(addr);
        count_before = req_count;
        ahb_read(addr, data, resp, stall);
        check($sformatf("hrdata of %h", addr), data, expected_word(addr));
        check($sformatf("hresp of %h", addr), resp, OKAY);
        check("mem_req after read", mem_req, 1'b0);
        if (hit_expected) begin
            check("hready low cycles on hit", stall, 0);
            check("req_count change on hit", req_count - count_before, 0);
        end else begin
            check("hready low beyond ack delay", stall > ack_delay, 1'b1);
            check("req_count change on miss", req_count - count_before, 1);
            check("mem_addr on miss", mem_addr, addr[ADDR_W-1:2]);
            record_fill(addr);
        end
    endtask

    task automatic back_to_back_reads(input logic [ADDR_W-1:0] addr0,
                                      input logic [ADDR_W-1:0] addr1);
        logic [DATA_W-1:0] data0;
        logic [DATA_W-1:0] data1;
        hresp_e            resp0;
        hresp_e            resp1;
        int                stall0;
        int                stall1;
        logic [31:0]       count_before;
        count_before = req_count;
        @(negedge cpu_intf);
        drive_read(addr0);
        @(posedge cpu_intf);
        @(negedge cpu_intf);
        haddr = addr1;  // held as the next address phase while the first miss stalls
        wait_data_phase(stall0);
        data0 = hrdata;
        resp0 = hresp;
        @(posedge cpu_intf);
        @(negedge cpu_intf);
        htrans = IDLE;
        wait_data_phase(stall1);
        data1 = hrdata;
        resp1 = hresp;
        @(posedge cpu_intf);
        check("hrdata of first pair read", data0, expected_word(addr0));
        check("hrdata of second pair read", data1, expected_word(addr1));
        check("hresp of pair reads", {resp0, resp1}, {OKAY, OKAY});
        check("hready low beyond ack delay, first", stall0 > ack_delay, 1'b1);
        check("hready low beyond ack delay, second", stall1 > ack_delay, 1'b1);
        check("req_count change over pair", req_count - count_before, 2);
        record_fill(addr0);
        record_fill(addr1);
    endtask

    task automatic ahb_write_expect_error(input logic [ADDR_W-1:0] addr);
        logic [31:0] count_before;
        count_before = req_count;
        @(negedge cpu_intf);
        drive_read(addr);
        hwrite = 1'b1;
        @(posedge cpu_intf);
        @(negedge cpu_intf);
        htrans = IDLE;
        hwrite = 1'b0;
        check("hready in first error cycle", hready, 1'b0);
        check("hresp in first error cycle", hresp, ERROR);
        @(posedge cpu_intf);
        @(negedge cpu_intf);
        check("hready in second error cycle", hready, 1'b1);
        check("hresp in second error cycle", hresp, ERROR);
        @(posedge cpu_intf);
        check("req_count change on write", req_count - count_before, 0);
    endtask

    task automatic evict_conflicting_line();
        logic [31:0] count_before;
        count_before = req_count;
        read_and_check(32'h0000_0A80);  // shares index 0 with 0x0A40 under another tag
        read_and_check(32'h0000_0A40);
        read_and_check(32'h0000_0A80);
        check("req_count over conflict reads", req_count - count_before, 3);
    endtask

    task automatic reject_write();
        ahb_write_expect_error(32'h0000_0A10);
        read_and_check(32'h0000_0A10);
    endtask

    task automatic stall_on_slow_ack();
        @(negedge cpu_intf);
        ack_delay = SLOW_DELAY;
        read_and_check(32'h0000_0A24);
        back_to_back_reads(32'h0000_0AC8, 32'h0000_0A34);
    endtask

    task automatic mix_random_reads();
        logic [ADDR_W-1:0] issued [$];
        logic [ADDR_W-1:0] addr;
        logic [31:0]       count_before;
        int                misses_before;
        int                i;
        @(negedge cpu_intf);
        ack_delay     = MIX_DELAY;
        count_before  = req_count;
        misses_before = predicted_misses;
        for (i = 0; i < MIX_READS; i++) begin
            if (issued.size() > 0 && ($random(seed) & 1)) begin
                addr = issued[{$random(seed)} % issued.size()];  // repeat an earlier address
            end else begin
                addr = 32'h0000_0A00 + (({$random(seed)} % 64) << 2);
                issued.push_back(addr);
            end
            read_and_check(addr);
        end
        check("req_count over random mix", req_count - count_before,
              predicted_misses - misses_before);
    endtask

    initial begin
        int i;
        rst_n     = 1'b0;
        haddr     = '0;
        htrans    = IDLE;
        hwrite    = 1'b0;
        hburst    = SINGLE;
        hsize     = HSIZE_WORD;
        ack_delay = DEFAULT_DELAY;
        seed      = 51;
        predicted_misses = 0;
        for (i = 0; i < LINE_COUNT; i++) begin
            sb_valid[i] = 1'b0;
            sb_tag[i]   = '0;
        end
        repeat (5) @(posedge cpu_intf);
        @(negedge cpu_intf);
        rst_n = 1'b1;
        read_and_check(32'h0000_0A40);  // cold miss
        read_and_check(32'h0000_0A40);  // hit with no stall
        evict_conflicting_line();
        reject_write();
        stall_on_slow_ack();
        mix_random_reads();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge cpu_intf);
        $display("the run timed out with no result after %0d clock cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

endmodule

`default_nettype wire
